/* hdl/ecc_pkg.sv */
package ecc_pkg;

    localparam int DATA_W   = 50;
    localparam int PARITY_W = 7;
    localparam int CODE_W   = DATA_W + PARITY_W;
    localparam int ADDR_W   = 6;
    localparam int DEPTH    = 64;
    localparam int CNT_W    = 16;

    // parity sits in the upper bits of the codeword.
    typedef struct packed {
        logic [PARITY_W-1:0] parity;
        logic [DATA_W-1:0]   data;
    } ecc_word_t;

    typedef union packed {
        ecc_word_t         f;
        logic [CODE_W-1:0] raw; // raw bit positions, as used by fault injection.
    } ecc_codeword_u;

    typedef struct packed {
        logic              wr_en;
        logic              rd_en;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [CODE_W-1:0] flip;
    } mem_req_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic              sbit_err;
        logic              dbit_err;
    } rd_resp_t;

    typedef struct packed {
        logic [CNT_W-1:0]  sbit_cnt;
        logic [CNT_W-1:0]  dbit_cnt;
        logic [ADDR_W-1:0] first_addr;
        logic              first_valid;
    } err_status_t;

    // Hsiao check bits; every data column has odd weight of three or five.
    function automatic logic [PARITY_W-1:0] ecc_encode(input logic [DATA_W-1:0] d);
        logic [PARITY_W-1:0] p;
        p[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[11] ^ d[13] ^ d[15]
             ^ d[17] ^ d[19] ^ d[21] ^ d[23] ^ d[25] ^ d[26] ^ d[28] ^ d[30] ^ d[32]
             ^ d[34] ^ d[36] ^ d[38] ^ d[40] ^ d[42] ^ d[44] ^ d[46] ^ d[48];
        p[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[10] ^ d[12] ^ d[13] ^ d[16]
             ^ d[17] ^ d[20] ^ d[21] ^ d[24] ^ d[25] ^ d[27] ^ d[28] ^ d[31] ^ d[32]
             ^ d[35] ^ d[36] ^ d[39] ^ d[40] ^ d[43] ^ d[44] ^ d[47] ^ d[48];
        p[2] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[10] ^ d[14] ^ d[15] ^ d[16]
             ^ d[17] ^ d[22] ^ d[23] ^ d[24] ^ d[25] ^ d[29] ^ d[30] ^ d[31] ^ d[32]
             ^ d[37] ^ d[38] ^ d[39] ^ d[40] ^ d[45] ^ d[46] ^ d[47] ^ d[48];
        p[3] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9] ^ d[10] ^ d[18] ^ d[19] ^ d[20]
             ^ d[21] ^ d[22] ^ d[23] ^ d[24] ^ d[25] ^ d[33] ^ d[34] ^ d[35] ^ d[36]
             ^ d[37] ^ d[38] ^ d[39] ^ d[40] ^ d[49];
        p[4] = ^d[25:11] ^ (^d[49:41]);
        p[5] = ^d[49:26];
        p[6] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[12] ^ d[14]
             ^ d[17] ^ d[18] ^ d[21] ^ d[23] ^ d[24] ^ d[26] ^ d[27] ^ d[29] ^ d[32]
             ^ d[33] ^ d[36] ^ d[38] ^ d[39] ^ d[41] ^ d[44] ^ d[46] ^ d[47];
        return p;
    endfunction

endpackage

/* hdl/ecc_50_cal.sv */
module ecc_50_cal
    import ecc_pkg::*;
(
    input  logic [DATA_W-1:0]   raw_data,
    input  logic [PARITY_W-1:0] stored_parity,
    input  logic                bypass,
    output logic [DATA_W-1:0]   fixed_data,
    output logic [PARITY_W-1:0] calc_parity,
    output logic [DATA_W-1:0]   mask,
    output logic                sbit_err,
    output logic                dbit_err
);

    logic [PARITY_W-1:0] syndrome;
    logic [5:0]          col;         // data bit named by the syndrome, all ones if none.
    logic                data_single;
    logic                par_single;
    logic                no_err;

    assign calc_parity = ecc_encode(raw_data);
    assign syndrome    = stored_parity ^ calc_parity;

    // each entry is the parity column of one data bit.
    always_comb begin
        case (syndrome)
            7'b1000011: col = 6'd0;
            7'b1000101: col = 6'd1;
            7'b1000110: col = 6'd2;
            7'b0000111: col = 6'd3;
            7'b1001001: col = 6'd4;
            7'b1001010: col = 6'd5;
            7'b0001011: col = 6'd6;
            7'b1001100: col = 6'd7;
            7'b0001101: col = 6'd8;
            7'b0001110: col = 6'd9;
            7'b1001111: col = 6'd10;
            7'b1010001: col = 6'd11;
            7'b1010010: col = 6'd12;
            7'b0010011: col = 6'd13;
            7'b1010100: col = 6'd14;
            7'b0010101: col = 6'd15;
            7'b0010110: col = 6'd16;
            7'b1010111: col = 6'd17;
            7'b1011000: col = 6'd18;
            7'b0011001: col = 6'd19;
            7'b0011010: col = 6'd20;
            7'b1011011: col = 6'd21;
            7'b0011100: col = 6'd22;
            7'b1011101: col = 6'd23;
            7'b1011110: col = 6'd24;
            7'b0011111: col = 6'd25;
            7'b1100001: col = 6'd26;
            7'b1100010: col = 6'd27;
            7'b0100011: col = 6'd28;
            7'b1100100: col = 6'd29;
            7'b0100101: col = 6'd30;
            7'b0100110: col = 6'd31;
            7'b1100111: col = 6'd32;
            7'b1101000: col = 6'd33;
            7'b0101001: col = 6'd34;
            7'b0101010: col = 6'd35;
            7'b1101011: col = 6'd36;
            7'b0101100: col = 6'd37;
            7'b1101101: col = 6'd38;
            7'b1101110: col = 6'd39;
            7'b0101111: col = 6'd40;
            7'b1110000: col = 6'd41;
            7'b0110001: col = 6'd42;
            7'b0110010: col = 6'd43;
            7'b1110011: col = 6'd44;
            7'b0110100: col = 6'd45;
            7'b1110101: col = 6'd46;
            7'b1110110: col = 6'd47;
            7'b0110111: col = 6'd48;
            7'b0111000: col = 6'd49;
            default:    col = '1;
        endcase
    end

    assign no_err      = (syndrome == '0);
    assign data_single = (col < DATA_W);
    assign par_single  = $onehot(syndrome); // a lone check bit flipped, data is intact.

    assign mask = data_single ? (DATA_W'(1) << col) : '0;

    // any other nonzero syndrome has even weight or no matching column.
    always_comb begin
        if (bypass) begin
            fixed_data = raw_data;
            sbit_err   = 1'b0;
            dbit_err   = 1'b0;
        end else begin
            fixed_data = raw_data ^ mask;
            sbit_err   = data_single || par_single;
            dbit_err   = !no_err && !data_single && !par_single;
        end
    end

endmodule

/* hdl/ecc_mem_array.sv */
module ecc_mem_array
    import ecc_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  mem_req_t          req,
    output ecc_codeword_u     rd_word,
    output logic [ADDR_W-1:0] rd_addr,
    output logic              rd_valid
);

    ecc_codeword_u mem [DEPTH];
    ecc_word_t     enc_word;
    ecc_codeword_u wr_word;

    assign enc_word = '{parity: ecc_encode(req.wdata), data: req.wdata};

    // injected faults land on raw codeword positions, parity included.
    always_comb begin
        wr_word.raw = enc_word ^ req.flip;
    end

    always_ff @(posedge clk) begin
        if (req.wr_en) begin
            mem[req.addr] <= wr_word;
        end
    end

    // a read of the address being written sees the old word.
    always_ff @(posedge clk) begin
        if (req.rd_en) begin
            rd_word <= mem[req.addr];
            rd_addr <= req.addr;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= req.rd_en; // high for the single cycle after the request.
        end
    end

endmodule

/* hdl/ecc_err_log.sv */
module ecc_err_log
    import ecc_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  rd_resp_t    resp,
    input  logic        err_clr,
    output err_status_t status
);

    logic [CNT_W-1:0]  sbit_cnt;
    logic [CNT_W-1:0]  dbit_cnt;
    logic [ADDR_W-1:0] first_addr;
    logic              first_valid;
    logic              sbit_hit;
    logic              dbit_hit;
    logic              any_hit;

    // count up by one on a hit and hold at the top value.
    function automatic logic [CNT_W-1:0] sat_inc(input logic [CNT_W-1:0] cnt,
                                                 input logic hit);
        logic [CNT_W-1:0] nxt;
        nxt = cnt;
        if (hit && (cnt != '1)) begin
            nxt = cnt + 1'b1;
        end
        return nxt;
    endfunction

    assign sbit_hit = resp.valid && resp.sbit_err;
    assign dbit_hit = resp.valid && resp.dbit_err;
    assign any_hit  = sbit_hit || dbit_hit;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sbit_cnt    <= '0;
            dbit_cnt    <= '0;
            first_valid <= 1'b0;
        end else if (err_clr) begin // a clear beats a flagged read in the same cycle.
            sbit_cnt    <= '0;
            dbit_cnt    <= '0;
            first_valid <= 1'b0;
        end else begin
            sbit_cnt <= sat_inc(sbit_cnt, sbit_hit);
            dbit_cnt <= sat_inc(dbit_cnt, dbit_hit);
            if (any_hit) begin
                first_valid <= 1'b1;
            end
        end
    end

    // only the first flagged read since reset or clear is kept.
    always_ff @(posedge clk) begin
        if (any_hit && !first_valid && !err_clr) begin
            first_addr <= resp.addr;
        end
    end

    assign status = '{
        sbit_cnt:    sbit_cnt,
        dbit_cnt:    dbit_cnt,
        first_addr:  first_addr,
        first_valid: first_valid
    };

endmodule

/* hdl/ecc_mem_top.sv */
module ecc_mem_top
    import ecc_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  mem_req_t    req,
    input  logic        bypass,
    input  logic        err_clr,
    output rd_resp_t    resp,
    output err_status_t status
);

    ecc_codeword_u     rd_word;
    logic [ADDR_W-1:0] rd_addr;
    logic              rd_valid;
    logic [DATA_W-1:0] fixed_data;
    logic              sbit_err;
    logic              dbit_err;

    ecc_mem_array u_array (
        .clk      (clk),
        .arst_n   (arst_n),
        .req      (req),
        .rd_word  (rd_word),
        .rd_addr  (rd_addr),
        .rd_valid (rd_valid)
    );

    // correction sits after the read register, in the response cycle.
    ecc_50_cal u_cal (
        .raw_data      (rd_word.f.data),
        .stored_parity (rd_word.f.parity),
        .bypass        (bypass),
        .fixed_data    (fixed_data),
        .calc_parity   (),
        .mask          (),
        .sbit_err      (sbit_err),
        .dbit_err      (dbit_err)
    );

    assign resp = '{
        valid:    rd_valid,
        addr:     rd_addr,
        data:     fixed_data,
        sbit_err: sbit_err,
        dbit_err: dbit_err
    };

    ecc_err_log u_log (
        .clk     (clk),
        .arst_n  (arst_n),
        .resp    (resp),
        .err_clr (err_clr),
        .status  (status)
    );

endmodule

/* verif/ecc_mem_checker.sv */
module ecc_mem_checker
    import ecc_pkg::*;
(
    input logic        clk,
    input logic        arst_n,
    input mem_req_t    req,
    input logic        err_clr,
    input rd_resp_t    resp,
    input err_status_t status
);

    timeunit 1ns;
    timeprecision 100ps;

    a_flags_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        resp.valid |-> !(resp.sbit_err && resp.dbit_err))
        else $error("single and double error flags are high together");

    // a read strobe at one edge gives exactly one valid cycle after it.
    a_valid_timing: assert property (@(posedge clk) disable iff (!arst_n)
        resp.valid == $past(req.rd_en))
        else $error("read response valid does not follow the read strobe by one cycle");

    a_cnt_monotonic: assert property (@(posedge clk) disable iff (!arst_n)
        !$past(err_clr) |-> (status.sbit_cnt >= $past(status.sbit_cnt))
                         && (status.dbit_cnt >= $past(status.dbit_cnt)))
        else $error("an error counter went down without a clear");

    a_valid_in_reset: assert property (@(posedge clk)
        !arst_n |-> !resp.valid)
        else $error("read response valid is high during reset");

endmodule

bind ecc_mem_top ecc_mem_checker u_checker (
    .clk     (clk),
    .arst_n  (arst_n),
    .req     (req),
    .err_clr (err_clr),
    .resp    (resp),
    .status  (status)
);

/* verif/ecc_mem_tb.sv */
module ecc_mem_tb
    import ecc_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic        clk;
    logic        arst_n;
    mem_req_t    req;
    logic        bypass;
    logic        err_clr;
    rd_resp_t    resp;
    err_status_t status;

    int err_cnt;
    int timeout_cnt;

    // expected state of the error log, kept from the read results.
    logic [CNT_W-1:0]  exp_sbit_cnt;
    logic [CNT_W-1:0]  exp_dbit_cnt;
    logic [ADDR_W-1:0] exp_first_addr;
    logic              exp_first_valid;

    ecc_mem_top u_ecc_mem_top (
        .clk     (clk),
        .arst_n  (arst_n),
        .req     (req),
        .bypass  (bypass),
        .err_clr (err_clr),
        .resp    (resp),
        .status  (status)
    );

    always #50 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        err_cnt++;
        $display("FAIL %s expected 0x%h actual 0x%h", name, exp, act);
    endtask

    function automatic logic [DATA_W-1:0] random_data();
        return DATA_W'({$urandom, $urandom});
    endfunction

    // sets nbits distinct raw codeword positions.
    function automatic logic [CODE_W-1:0] flip_bits(input int nbits);
        logic [CODE_W-1:0] fl;
        fl = '0;
        while ($countones(fl) < nbits) begin
            fl[$urandom_range(CODE_W - 1, 0)] = 1'b1;
        end
        return fl;
    endfunction

    function automatic mem_req_t read_req(input logic [ADDR_W-1:0] addr);
        mem_req_t r;
        r       = '0;
        r.rd_en = 1'b1;
        r.addr  = addr;
        return r;
    endfunction

    task automatic clear_model();
        exp_sbit_cnt    = '0;
        exp_dbit_cnt    = '0;
        exp_first_addr  = '0;
        exp_first_valid = 1'b0;
    endtask

    task automatic log_model(input logic [ADDR_W-1:0] addr, input logic s, input logic d);
        if (s && exp_sbit_cnt != '1) exp_sbit_cnt++;
        if (d && exp_dbit_cnt != '1) exp_dbit_cnt++;
        if ((s || d) && !exp_first_valid) begin
            exp_first_valid = 1'b1;
            exp_first_addr  = addr;
        end
    endtask

    // the log updates at the edge that ends a response, so look one negedge later.
    task automatic check_status();
        @(negedge clk);
        if (status.sbit_cnt !== exp_sbit_cnt)
            report_mismatch("status.sbit_cnt", 64'(exp_sbit_cnt), 64'(status.sbit_cnt));
        if (status.dbit_cnt !== exp_dbit_cnt)
            report_mismatch("status.dbit_cnt", 64'(exp_dbit_cnt), 64'(status.dbit_cnt));
        if (status.first_valid !== exp_first_valid)
            report_mismatch("status.first_valid", 64'(exp_first_valid),
                            64'(status.first_valid));
        if (exp_first_valid && status.first_addr !== exp_first_addr)
            report_mismatch("status.first_addr", 64'(exp_first_addr), 64'(status.first_addr));
    endtask

    task automatic compare_resp(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                                input logic s, input logic d);
        if (resp.addr !== addr)
            report_mismatch("resp.addr", 64'(addr), 64'(resp.addr));
        if (!d && resp.data !== data) // data is not defined for a double error.
            report_mismatch("resp.data", 64'(data), 64'(resp.data));
        if (resp.sbit_err !== s)
            report_mismatch("resp.sbit_err", 64'(s), 64'(resp.sbit_err));
        if (resp.dbit_err !== d)
            report_mismatch("resp.dbit_err", 64'(d), 64'(resp.dbit_err));
    endtask

    task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wd,
                              input logic [CODE_W-1:0] fl);
        @(posedge clk);
        req    <= '{wr_en: 1'b1, rd_en: 1'b0, addr: addr, wdata: wd, flip: fl};
        bypass <= 1'b0;
        @(posedge clk);
        req    <= '0;
    endtask

    task automatic read_check(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                              input logic s, input logic d, input logic byp);
        logic ok;
        ok = 1'b0;
        @(posedge clk);
        req    <= read_req(addr);
        bypass <= byp;
        @(posedge clk);
        req    <= '0;
        for (int n = 0; n < 4 && !ok; n++) begin
            @(negedge clk);
            ok = resp.valid;
        end
        if (!ok) begin
            timeout_cnt++;
            $display("timeout: no read response for address %0d", addr);
        end else begin
            compare_resp(addr, data, s, d);
            if (!byp) log_model(addr, s, d);
        end
    endtask

    task automatic clean_read_all();
        logic [DATA_W-1:0] img [DEPTH];
        for (int a = 0; a < DEPTH; a++) begin
            img[a] = random_data();
            write_word(ADDR_W'(a), img[a], '0);
        end
        for (int a = 0; a < DEPTH; a++) read_check(ADDR_W'(a), img[a], 1'b0, 1'b0, 1'b0);
        check_status();
    endtask

    task automatic correct_single_bits();
        logic [DATA_W-1:0] wd;
        logic [CODE_W-1:0] fl;
        for (int p = 0; p < CODE_W; p++) begin
            wd    = random_data();
            fl    = '0;
            fl[p] = 1'b1; // every raw position, the parity field included.
            write_word(ADDR_W'(p), wd, fl);
            read_check(ADDR_W'(p), wd, 1'b1, 1'b0, 1'b0);
        end
        check_status();
    endtask

    task automatic detect_double_bits();
        logic [DATA_W-1:0] wd;
        logic [ADDR_W-1:0] addr;
        for (int i = 0; i < 8; i++) begin
            wd   = random_data();
            addr = ADDR_W'($urandom_range(DEPTH - 1, 0));
            write_word(addr, wd, flip_bits(2));
            read_check(addr, wd, 1'b0, 1'b1, 1'b0);
            check_status();
        end
    endtask

    task automatic read_with_bypass();
        logic [DATA_W-1:0] wd;
        logic [CODE_W-1:0] fl;
        logic [ADDR_W-1:0] addr;
        for (int i = 0; i < 6; i++) begin
            wd   = random_data();
            fl   = flip_bits(1 + int'($urandom_range(1, 0)));
            addr = ADDR_W'($urandom_range(DEPTH - 1, 0));
            write_word(addr, wd, fl);
            read_check(addr, wd ^ fl[DATA_W-1:0], 1'b0, 1'b0, 1'b1);
            check_status();
        end
    endtask

    task automatic pipeline_then_clear();
        logic [DATA_W-1:0] img [8];
        logic              sb [8];
        for (int i = 0; i < 8; i++) begin
            img[i] = random_data();
            sb[i]  = (i % 2 == 1);
            write_word(ADDR_W'(i), img[i], sb[i] ? flip_bits(1) : '0);
        end
        // one read per edge, each response checked in the cycle right after its request.
        for (int i = 0; i <= 8; i++) begin
            @(posedge clk);
            req <= (i < 8) ? read_req(ADDR_W'(i)) : '0;
            @(negedge clk);
            if (i > 0) begin
                if (!resp.valid) begin
                    err_cnt++;
                    $display("read response for address %0d missing in its cycle", i - 1);
                end else begin
                    compare_resp(ADDR_W'(i - 1), img[i-1], sb[i-1], 1'b0);
                    log_model(ADDR_W'(i - 1), sb[i-1], 1'b0);
                end
            end
        end
        check_status();
        @(posedge clk);
        err_clr <= 1'b1;
        @(posedge clk);
        err_clr <= 1'b0;
        clear_model();
        check_status();
        // a flagged read whose response meets a clear is not counted.
        @(posedge clk);
        req <= read_req(ADDR_W'(1));
        @(posedge clk);
        req     <= '0;
        err_clr <= 1'b1;
        @(negedge clk);
        if (!resp.valid) begin
            err_cnt++;
            $display("read response for address 1 missing in its cycle");
        end else begin
            compare_resp(ADDR_W'(1), img[1], 1'b1, 1'b0);
        end
        @(posedge clk);
        err_clr <= 1'b0;
        check_status();
    endtask

    initial begin
        for (int c = 0; c < 20000; c++) @(posedge clk);
        $display("simulation ran too long and was stopped");
        $display("Checks failed");
        $finish;
    end

    initial begin
        void'($urandom(76));
        clk         = 1'b0;
        arst_n      = 1'b0;
        req         = '0;
        bypass      = 1'b0;
        err_clr     = 1'b0;
        err_cnt     = 0;
        timeout_cnt = 0;
        clear_model();
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        check_status();
        clean_read_all();
        correct_single_bits();
        detect_double_bits();
        read_with_bypass();
        pipeline_then_clear();
        @(posedge clk);
        $display("errors: %0d mismatches, %0d timeouts", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* sources.f */
hdl/ecc_pkg.sv
hdl/ecc_50_cal.sv
hdl/ecc_mem_array.sv
hdl/ecc_err_log.sv
hdl/ecc_mem_top.sv
verif/ecc_mem_checker.sv
verif/ecc_mem_tb.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module ecc_mem_tb \
    -Mdir obj_dir \
    -f sources.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/Vecc_mem_tb 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "All checks passed"; then
    exit 0
fi

echo "simulation did not report success"
exit 1
